// File: design/clic_pkg.sv
// vec_size above 32 would make the vector csr window run into the entry csr window
`default_nettype none

package clic_pkg;

  // csr data word and address
  typedef logic [31:0] word;
  typedef logic [11:0] csr_addr_t;

  // instruction byte address seen by the core
  typedef logic [31:0] imem_addr_t;

  // zicsr funct3 encoding, bit 2 selects the immediate source
  typedef enum logic [2:0] {
    csr_rw  = 3'b001,
    csr_rs  = 3'b010,
    csr_rc  = 3'b011,
    csr_rwi = 3'b101,
    csr_rsi = 3'b110,
    csr_rci = 3'b111
  } csr_op_t;

  // interrupt lines and priority levels
  localparam int vec_size    = 8;
  localparam int prio_levels = 8;
  localparam int prio_width  = 3;

  // vector csr keeps a word address, low two pc bits are implied zero
  localparam int vec_width   = 30;

  // entry layout is {prio[2:0], enabled, pended}
  localparam int entry_width = 5;

  // nesting counter, must hold 0 up to prio_levels
  localparam int depth_width = 4;

  // csr map
  localparam csr_addr_t csr_thresh_addr = 12'h347;
  localparam csr_addr_t csr_depth_addr  = 12'h350;
  localparam csr_addr_t csr_vec_base    = 12'hb00;
  localparam csr_addr_t csr_entry_base  = 12'hb20;

  // pc value the core presents on interrupt return
  localparam imem_addr_t ret_pc = '1;

endpackage

`default_nettype wire

// File: design/clic_table_if.sv
// threshold and table are registered in the csr block, so the arbiter sees them one cycle after a write
`timescale 1ns/1ps
`default_nettype none

interface clic_table_if
  import clic_pkg::*;
;

  // vector word address per line
  logic [vec_size-1:0][vec_width-1:0]  vec;

  // entry fields split out per line
  logic [vec_size-1:0][prio_width-1:0] prio;
  logic [vec_size-1:0]                 enabled;
  logic [vec_size-1:0]                 pended;

  // current interrupt threshold
  logic [prio_width-1:0]               threshold;

  // csr side owns every field
  modport regs (
    output vec,
    output prio,
    output enabled,
    output pended,
    output threshold
  );

  // arbiter only looks
  modport arb (
    input vec,
    input prio,
    input enabled,
    input pended,
    input threshold
  );

endinterface

`default_nettype wire

// File: design/clic_csr_file.sv
// pending bits are never cleared by hardware and a hardware threshold write overrides software
`timescale 1ns/1ps
`default_nettype none

module clic_csr_file
  import clic_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   csr_enable,
  input  csr_addr_t              csr_addr,
  input  csr_op_t                csr_op,
  input  logic [4:0]             rs1_zimm,
  input  word                    rs1_data,
  input  logic                   thresh_we,
  input  logic [prio_width-1:0]  thresh_data,
  input  logic [depth_width-1:0] depth,
  output word                    csr_out,
  clic_table_if.regs             tbl
);

  // register state and next values
  logic [prio_width-1:0]                thresh_q;
  logic [prio_width-1:0]                thresh_d;
  logic [vec_size-1:0][vec_width-1:0]   vec_q;
  logic [vec_size-1:0][vec_width-1:0]   vec_d;
  logic [vec_size-1:0][entry_width-1:0] entry_q;
  logic [vec_size-1:0][entry_width-1:0] entry_d;

  // operand after immediate select
  word src;

  // rw replaces, rs sets, rc clears
  function automatic word apply_op(input csr_op_t op, input word old_val, input word src_val);
    word res;
    case (op)
      csr_rw, csr_rwi: res = src_val;
      csr_rs, csr_rsi: res = old_val | src_val;
      csr_rc, csr_rci: res = old_val & ~src_val;
      default:         res = old_val;
    endcase
    return res;
  endfunction

  // zero extended zimm for the i forms
  assign src = (csr_op inside {csr_rwi, csr_rsi, csr_rci}) ? word'(rs1_zimm) : rs1_data;

  // software write decode
  always_comb begin
    thresh_d = thresh_q;
    vec_d    = vec_q;
    entry_d  = entry_q;
    if (csr_enable) begin
      if (csr_addr == csr_thresh_addr) begin
        thresh_d = prio_width'(apply_op(csr_op, word'(thresh_q), src));
      end
      for (int k = 0; k < vec_size; k++) begin
        if (csr_addr == csr_addr_t'(csr_vec_base + k)) begin
          vec_d[k] = vec_width'(apply_op(csr_op, word'(vec_q[k]), src));
        end
        if (csr_addr == csr_addr_t'(csr_entry_base + k)) begin
          entry_d[k] = entry_width'(apply_op(csr_op, word'(entry_q[k]), src));
        end
      end
    end
    // take or return from ctrl beats software
    if (thresh_we) begin
      thresh_d = thresh_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      thresh_q <= '0;
      vec_q    <= '0;
      entry_q  <= '0;
    end else begin
      thresh_q <= thresh_d;
      vec_q    <= vec_d;
      entry_q  <= entry_d;
    end
  end

  // readback shows pre-write value, unmapped reads 0
  always_comb begin
    csr_out = '0;
    if (csr_addr == csr_thresh_addr) begin
      csr_out = word'(thresh_q);
    end
    if (csr_addr == csr_depth_addr) begin
      csr_out = word'(depth);
    end
    for (int k = 0; k < vec_size; k++) begin
      if (csr_addr == csr_addr_t'(csr_vec_base + k)) begin
        csr_out = word'(vec_q[k]);
      end
      if (csr_addr == csr_addr_t'(csr_entry_base + k)) begin
        csr_out = word'(entry_q[k]);
      end
    end
  end

  // table out to the arbiter
  assign tbl.vec       = vec_q;
  assign tbl.threshold = thresh_q;

  // entry bit slices
  for (genvar k = 0; k < vec_size; k++) begin : g_entry
    assign tbl.pended[k]  = entry_q[k][0];
    assign tbl.enabled[k] = entry_q[k][1];
    assign tbl.prio[k]    = entry_q[k][entry_width-1 -: prio_width];
  end

endmodule

`default_nettype wire

// File: design/clic_prio_arbiter.sv
// purely combinational, so the chain length grows with vec_size and sits in the pc_out path
`timescale 1ns/1ps
`default_nettype none

module clic_prio_arbiter
  import clic_pkg::*;
(
  clic_table_if.arb              tbl,
  output logic                   is_int,
  output logic [prio_width-1:0]  max_prio,
  output logic [vec_width-1:0]   max_vec
);

  // candidate lines before the priority compare
  logic [vec_size-1:0] elig;

  assign elig = tbl.enabled & tbl.pended;

  // chain seeded with the threshold
  // strict greater keeps the lower index on a tie
  always_comb begin
    is_int   = 1'b0;
    max_prio = tbl.threshold;
    max_vec  = '0;
    for (int k = 0; k < vec_size; k++) begin
      if (elig[k] && (tbl.prio[k] > max_prio)) begin
        is_int   = 1'b1;
        max_prio = tbl.prio[k];
        max_vec  = tbl.vec[k];
      end
    end
  end

  // with no winner max_prio stays at threshold
  // and max_vec at zero, ctrl ignores both then

endmodule

`default_nettype wire

// File: design/clic_epc_stack.sv
// a push onto a full stack is dropped and a pop from an empty one reads 0 with depth held at 0
`timescale 1ns/1ps
`default_nettype none

module clic_epc_stack
  import clic_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push,
  input  logic                   pop,
  input  imem_addr_t             push_pc,
  input  logic [prio_width-1:0]  push_prio,
  output imem_addr_t             top_pc,
  output logic [prio_width-1:0]  top_prio,
  output logic [depth_width-1:0] depth
);

  // one slot per nesting level
  imem_addr_t            pc_mem   [prio_levels];
  logic [prio_width-1:0] prio_mem [prio_levels];

  logic [depth_width-1:0]         depth_q;
  logic [$clog2(prio_levels)-1:0] wr_idx;
  logic [$clog2(prio_levels)-1:0] top_idx;
  logic                           full;
  logic                           empty;

  assign full    = (depth_q == depth_width'(prio_levels));
  assign empty   = (depth_q == '0);
  assign wr_idx  = depth_q[$clog2(prio_levels)-1:0];
  assign top_idx = wr_idx - 1'b1;

  // payload slots, no reset needed
  always_ff @(posedge clk) begin
    if (push && !full) begin
      pc_mem[wr_idx]   <= push_pc;
      prio_mem[wr_idx] <= push_prio;
    end
  end

  // depth counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      depth_q <= '0;
    end else if (push && !full) begin
      depth_q <= depth_q + 1'b1;
    end else if (pop && !empty) begin
      depth_q <= depth_q - 1'b1;
    end
  end

  // empty stack reads as zero
  assign top_pc   = empty ? '0 : pc_mem[top_idx];
  assign top_prio = empty ? '0 : prio_mem[top_idx];
  assign depth    = depth_q;

endmodule

`default_nettype wire

// File: design/clic_ctrl.sv
// decision is combinational from pc_in every cycle, so the core must hold pc_in stable until the edge
`timescale 1ns/1ps
`default_nettype none

module clic_ctrl
  import clic_pkg::*;
(
  input  imem_addr_t            pc_in,
  input  logic                  is_int,
  input  logic [prio_width-1:0] max_prio,
  input  logic [vec_width-1:0]  max_vec,
  input  logic [prio_width-1:0] threshold,
  input  imem_addr_t            top_pc,
  input  logic [prio_width-1:0] top_prio,
  output logic                  push,
  output logic                  pop,
  output imem_addr_t            push_pc,
  output logic [prio_width-1:0] push_prio,
  output logic                  thresh_we,
  output logic [prio_width-1:0] thresh_data,
  output imem_addr_t            pc_out,
  output logic                  interrupt_out
);

  logic is_ret;

  // core signals mret with the all ones marker
  assign is_ret = (pc_in == ret_pc);

  // frame contents, strobed by push
  assign push_pc   = pc_in;
  assign push_prio = threshold;

  always_comb begin
    push          = 1'b0;
    pop           = 1'b0;
    thresh_we     = 1'b0;
    thresh_data   = max_prio;
    pc_out        = pc_in;
    interrupt_out = 1'b0;
    if (is_ret && is_int) begin
      // tail chain, stack and threshold stay
      pc_out        = {max_vec, 2'b00};
      interrupt_out = 1'b1;
    end else if (is_int) begin
      // take and raise threshold
      push          = 1'b1;
      thresh_we     = 1'b1;
      pc_out        = {max_vec, 2'b00};
      interrupt_out = 1'b1;
    end else if (is_ret) begin
      // unwind one level
      pop         = 1'b1;
      thresh_we   = 1'b1;
      thresh_data = top_prio;
      pc_out      = top_pc;
    end
  end

endmodule

`default_nettype wire

// File: design/n_clic.sv
// pc_out and interrupt_out are combinational from pc_in, and csr state changes only at the clock edge
`timescale 1ns/1ps
`default_nettype none

module n_clic
  import clic_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   csr_enable,
  input  csr_addr_t              csr_addr,
  input  csr_op_t                csr_op,
  input  logic [4:0]             rs1_zimm,
  input  word                    rs1_data,
  input  imem_addr_t             pc_in,
  output word                    csr_out,
  output imem_addr_t             pc_out,
  output logic [depth_width-1:0] level_out,
  output logic                   interrupt_out
);

  // arbiter result
  logic                  is_int;
  logic [prio_width-1:0] max_prio;
  logic [vec_width-1:0]  max_vec;

  // stack control and frame
  logic                  push;
  logic                  pop;
  imem_addr_t            push_pc;
  logic [prio_width-1:0] push_prio;
  imem_addr_t            top_pc;
  logic [prio_width-1:0] top_prio;

  // hardware threshold update
  logic                  thresh_we;
  logic [prio_width-1:0] thresh_data;

  // csr table to arbiter
  clic_table_if tbl ();

  clic_csr_file u_csr (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_enable  (csr_enable),
    .csr_addr    (csr_addr),
    .csr_op      (csr_op),
    .rs1_zimm    (rs1_zimm),
    .rs1_data    (rs1_data),
    .thresh_we   (thresh_we),
    .thresh_data (thresh_data),
    .depth       (level_out),
    .csr_out     (csr_out),
    .tbl         (tbl.regs)
  );

  clic_prio_arbiter u_arb (
    .tbl      (tbl.arb),
    .is_int   (is_int),
    .max_prio (max_prio),
    .max_vec  (max_vec)
  );

  // depth doubles as the nesting level output
  clic_epc_stack u_stack (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .pop       (pop),
    .push_pc   (push_pc),
    .push_prio (push_prio),
    .top_pc    (top_pc),
    .top_prio  (top_prio),
    .depth     (level_out)
  );

  clic_ctrl u_ctrl (
    .pc_in         (pc_in),
    .is_int        (is_int),
    .max_prio      (max_prio),
    .max_vec       (max_vec),
    .threshold     (tbl.threshold),
    .top_pc        (top_pc),
    .top_prio      (top_prio),
    .push          (push),
    .pop           (pop),
    .push_pc       (push_pc),
    .push_prio     (push_prio),
    .thresh_we     (thresh_we),
    .thresh_data   (thresh_data),
    .pc_out        (pc_out),
    .interrupt_out (interrupt_out)
  );

endmodule

`default_nettype wire

// File: bench/clk_gen.sv
// free running 100 ns clock, rst_n released at the rising edge after 3 cycles
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    // hold reset for three edges
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

  always #50 clk = ~clk;

endmodule

`default_nettype wire

// File: bench/n_clic_assertions.sv
// checks only while rst_n is high, on internal n_clic nets reached through bind
`timescale 1ns/1ps
`default_nettype none

module n_clic_assertions
  import clic_pkg::*;
(
  input logic                   clk,
  input logic                   rst_n,
  input logic                   push,
  input logic                   pop,
  input logic [depth_width-1:0] level
);

  // a take grows a non-full stack by one
  a_push: assert property (@(posedge clk) disable iff (!rst_n)
    push && level < prio_levels |=> level == $past(level) + 1'b1)
    else $error("push did not raise the stack depth by one");

  // a return unwinds a non-empty stack by one
  a_pop: assert property (@(posedge clk) disable iff (!rst_n)
    pop && level != 0 |=> level == $past(level) - 1'b1)
    else $error("pop did not lower the stack depth by one");

  // stack never deeper than the priority levels
  a_depth: assert property (@(posedge clk) disable iff (!rst_n) level <= prio_levels)
    else $error("stack depth above 8");

endmodule

bind n_clic n_clic_assertions u_asrt (
  .clk    (clk),
  .rst_n  (rst_n),
  .push   (push),
  .pop    (pop),
  .level  (level_out)
);

`default_nettype wire

// File: bench/n_clic_tb.sv
// every cycle is checked at the falling edge against a shadow model, first mismatch ends the run
`timescale 1ns/1ps
`default_nettype none

module n_clic_tb
  import clic_pkg::*;
;

  logic                   clk;
  logic                   rst_n;
  logic                   csr_enable;
  csr_addr_t              csr_addr;
  csr_op_t                csr_op;
  logic [4:0]             rs1_zimm;
  word                    rs1_data;
  imem_addr_t             pc_in;
  word                    csr_out;
  imem_addr_t             pc_out;
  logic [depth_width-1:0] level_out;
  logic                   interrupt_out;

  // predicted outputs plus the control decision behind them
  typedef struct packed {
    word                    csr;
    imem_addr_t             pc;
    logic                   intr;
    logic                   push;
    logic                   pop;
    logic                   twe;
    logic [prio_width-1:0]  tdata;
    logic [depth_width-1:0] level;
  } ref_t;

  // shadow csr table and stack
  logic [prio_width-1:0]  sh_thresh;
  logic [vec_width-1:0]   sh_vec   [vec_size];
  logic [entry_width-1:0] sh_entry [vec_size];
  imem_addr_t             sh_spc   [prio_levels];
  logic [prio_width-1:0]  sh_sprio [prio_levels];
  logic [depth_width-1:0] sh_depth;

  string  test_name;
  int     errors;
  ref_t   exp_r;

  clk_gen u_clk (.clk(clk), .rst_n(rst_n));

  n_clic u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .csr_enable    (csr_enable),
    .csr_addr      (csr_addr),
    .csr_op        (csr_op),
    .rs1_zimm      (rs1_zimm),
    .rs1_data      (rs1_data),
    .pc_in         (pc_in),
    .csr_out       (csr_out),
    .pc_out        (pc_out),
    .level_out     (level_out),
    .interrupt_out (interrupt_out)
  );

  function automatic word csr_read(input csr_addr_t addr);
    word v;
    v = '0;
    if (addr == csr_thresh_addr) v = word'(sh_thresh);
    if (addr == csr_depth_addr) v = word'(sh_depth);
    for (int k = 0; k < vec_size; k++) begin
      if (addr == csr_addr_t'(csr_vec_base + k)) v = word'(sh_vec[k]);
      if (addr == csr_addr_t'(csr_entry_base + k)) v = word'(sh_entry[k]);
    end
    return v;
  endfunction

  // expected outputs from current shadow state and inputs
  function automatic ref_t ref_predict(input csr_addr_t addr, input imem_addr_t pc);
    ref_t                  r;
    logic                  hit;
    logic [prio_width-1:0] best;
    logic [vec_width-1:0]  bvec;
    r    = '0;
    hit  = 1'b0;
    best = sh_thresh;
    bvec = '0;
    // strictly above threshold, lowest index on ties
    for (int k = 0; k < vec_size; k++) begin
      if (sh_entry[k][1:0] == 2'b11 && sh_entry[k][4:2] > best) begin
        hit  = 1'b1;
        best = sh_entry[k][4:2];
        bvec = sh_vec[k];
      end
    end
    r.pc    = pc;
    r.level = sh_depth;
    r.csr   = csr_read(addr);
    if (hit) begin
      r.intr = 1'b1;
      r.pc   = {bvec, 2'b00};
      if (pc != ret_pc) begin
        r.push  = 1'b1;
        r.twe   = 1'b1;
        r.tdata = best;
      end
    end else if (pc == ret_pc) begin
      r.pop = 1'b1;
      r.twe = 1'b1;
      if (sh_depth != 0) begin
        r.tdata = sh_sprio[sh_depth[2:0] - 3'd1];
        r.pc    = sh_spc[sh_depth[2:0] - 3'd1];
      end else begin
        r.pc = '0;
      end
    end
    return r;
  endfunction

  function automatic word op_result(input csr_op_t op, input word old_v, input word src);
    if (op == csr_rw || op == csr_rwi) return src;
    if (op == csr_rs || op == csr_rsi) return old_v | src;
    return old_v & ~src;
  endfunction

  // state the dut takes at the next rising edge
  task automatic apply_update(input ref_t r);
    word                   src;
    logic [prio_width-1:0] old_t;
    old_t = sh_thresh;
    src   = (csr_op inside {csr_rwi, csr_rsi, csr_rci}) ? word'(rs1_zimm) : rs1_data;
    if (csr_enable) begin
      if (csr_addr == csr_thresh_addr)
        sh_thresh = prio_width'(op_result(csr_op, word'(sh_thresh), src));
      for (int k = 0; k < vec_size; k++) begin
        if (csr_addr == csr_addr_t'(csr_vec_base + k))
          sh_vec[k] = vec_width'(op_result(csr_op, word'(sh_vec[k]), src));
        if (csr_addr == csr_addr_t'(csr_entry_base + k))
          sh_entry[k] = entry_width'(op_result(csr_op, word'(sh_entry[k]), src));
      end
    end
    // hardware threshold write wins
    if (r.twe) sh_thresh = r.tdata;
    if (r.push && sh_depth < prio_levels) begin
      sh_spc[sh_depth[2:0]]   = pc_in;
      sh_sprio[sh_depth[2:0]] = old_t;
      sh_depth = sh_depth + 1'b1;
    end else if (r.pop && sh_depth != 0) begin
      sh_depth = sh_depth - 1'b1;
    end
  endtask

  task automatic reset_shadow();
    sh_thresh = '0;
    sh_depth  = '0;
    for (int k = 0; k < vec_size; k++) begin
      sh_vec[k]   = '0;
      sh_entry[k] = '0;
    end
  endtask

  task automatic mismatch();
    errors++;
    $display("Regression failed");
    $fatal(1, "mismatch in %s", test_name);
  endtask

  task automatic check_word(input string name, input word exp_v, input word act_v);
    if (exp_v !== act_v) begin
      $display("FAIL %s csr_out expected %h actual %h", name, exp_v, act_v);
      mismatch();
    end
  endtask

  task automatic check_pc(input string name, input imem_addr_t exp_v, input imem_addr_t act_v);
    if (exp_v !== act_v) begin
      $display("FAIL %s pc_out expected %h actual %h", name, exp_v, act_v);
      mismatch();
    end
  endtask

  task automatic check_depth(input string name, input logic [depth_width-1:0] exp_v,
                             input logic [depth_width-1:0] act_v);
    if (exp_v !== act_v) begin
      $display("FAIL %s level_out expected %0d actual %0d", name, exp_v, act_v);
      mismatch();
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (exp_v !== act_v) begin
      $display("FAIL %s interrupt_out expected %b actual %b", name, exp_v, act_v);
      mismatch();
    end
  endtask

  // compare just before the next rising edge
  always @(negedge clk) begin
    if (!rst_n) begin
      reset_shadow();
    end else begin
      exp_r = ref_predict(csr_addr, pc_in);
      check_word(test_name, exp_r.csr, csr_out);
      check_pc(test_name, exp_r.pc, pc_out);
      check_bit(test_name, exp_r.intr, interrupt_out);
      check_depth(test_name, exp_r.level, level_out);
      apply_update(exp_r);
    end
  end

  function automatic imem_addr_t rand_pc();
    // never the return marker
    return imem_addr_t'($urandom()) & 32'h7fff_fffc;
  endfunction

  function automatic word mk_entry(input int prio, input bit en, input bit pend);
    return word'({prio[2:0], en, pend});
  endfunction

  task automatic drive(input logic en, input csr_addr_t addr, input csr_op_t op,
                       input logic [4:0] zimm, input word data, input imem_addr_t pc);
    @(posedge clk);
    csr_enable <= en;
    csr_addr   <= addr;
    csr_op     <= op;
    rs1_zimm   <= zimm;
    rs1_data   <= data;
    pc_in      <= pc;
  endtask

  task automatic write_csr(input csr_addr_t addr, input word data);
    drive(1'b1, addr, csr_rw, 5'd0, data, rand_pc());
  endtask

  task automatic read_csr(input csr_addr_t addr);
    drive(1'b0, addr, csr_rw, 5'd0, '0, rand_pc());
  endtask

  // clear the table and return until the stack is empty
  task automatic unwind();
    for (int k = 0; k < vec_size; k++)
      drive(1'b1, csr_addr_t'(csr_entry_base + k), csr_rw, 5'd0, '0, ret_pc);
    for (int n = 0; n < 10 && sh_depth != 0; n++)
      drive(1'b0, csr_depth_addr, csr_rw, 5'd0, '0, ret_pc);
    write_csr(csr_thresh_addr, '0);
    read_csr(csr_depth_addr);
  endtask

  // watchdog, six tests of at most 200 cycles plus reset
  initial begin
    #((6 * 200 + 3) * 100);
    $display("simulation timed out before all tests finished");
    $display("Regression failed");
    $fatal(1, "timeout");
  end

  initial begin
    csr_addr_t addr;
    csr_op_t   op;
    void'($urandom(13));
    errors     = 0;
    test_name  = "reset";
    csr_enable = 1'b0;
    csr_addr   = '0;
    csr_op     = csr_rw;
    rs1_zimm   = '0;
    rs1_data   = '0;
    pc_in      = '0;
    reset_shadow();
    @(posedge rst_n);

    // all csrs zero, pc passes through
    test_name = "reset_passthrough";
    read_csr(csr_thresh_addr);
    read_csr(csr_depth_addr);
    for (int k = 0; k < vec_size; k++) begin
      read_csr(csr_addr_t'(csr_vec_base + k));
      read_csr(csr_addr_t'(csr_entry_base + k));
    end

    test_name = "csr_ops";
    for (int n = 0; n < 30; n++) begin
      case ($urandom_range(0, 5))
        0: addr = csr_thresh_addr;
        1: addr = csr_depth_addr;
        2: addr = csr_addr_t'(csr_vec_base + $urandom_range(0, 7));
        3: addr = csr_addr_t'(csr_entry_base + $urandom_range(0, 7));
        4: addr = 12'h123;
        default: addr = 12'hb08;
      endcase
      case ($urandom_range(0, 5))
        0: op = csr_rw;
        1: op = csr_rs;
        2: op = csr_rc;
        3: op = csr_rwi;
        4: op = csr_rsi;
        default: op = csr_rci;
      endcase
      drive(1'b1, addr, op, 5'($urandom()), word'($urandom()), rand_pc());
      read_csr(addr);
    end
    unwind();

    // threshold at 7 holds everything off while the table is built
    test_name = "selection";
    write_csr(csr_thresh_addr, 32'd7);
    for (int k = 0; k < vec_size; k++) write_csr(csr_addr_t'(csr_vec_base + k), $urandom());
    write_csr(csr_entry_base + 12'd0, mk_entry(5, 0, 1));
    write_csr(csr_entry_base + 12'd1, mk_entry(4, 1, 1));
    write_csr(csr_entry_base + 12'd2, mk_entry(4, 1, 1));
    write_csr(csr_entry_base + 12'd3, mk_entry(2, 1, 1));
    write_csr(csr_entry_base + 12'd4, mk_entry(6, 1, 0));
    write_csr(csr_thresh_addr, 32'd2);
    repeat (3) read_csr(csr_thresh_addr);
    unwind();

    test_name = "take_nest";
    write_csr(csr_entry_base + 12'd0, mk_entry(2, 1, 1));
    repeat (2) read_csr(csr_thresh_addr);
    write_csr(csr_entry_base + 12'd3, mk_entry(1, 1, 1));
    write_csr(csr_entry_base + 12'd5, mk_entry(6, 1, 1));
    repeat (2) read_csr(csr_depth_addr);

    test_name = "return";
    drive(1'b1, csr_entry_base + 12'd5, csr_rci, 5'd1, '0, rand_pc());
    drive(1'b0, csr_thresh_addr, csr_rw, 5'd0, '0, ret_pc);
    read_csr(csr_thresh_addr);
    drive(1'b1, csr_entry_base + 12'd0, csr_rci, 5'd1, '0, rand_pc());
    drive(1'b0, csr_depth_addr, csr_rw, 5'd0, '0, ret_pc);
    read_csr(csr_thresh_addr);
    unwind();

    // pend lands one cycle before the return
    test_name = "tail_chain";
    write_csr(csr_entry_base + 12'd2, mk_entry(3, 1, 1));
    read_csr(csr_depth_addr);
    drive(1'b1, csr_entry_base + 12'd2, csr_rci, 5'd1, '0, rand_pc());
    write_csr(csr_entry_base + 12'd4, mk_entry(5, 1, 1));
    drive(1'b0, csr_depth_addr, csr_rw, 5'd0, '0, ret_pc);
    unwind();

    @(posedge clk);
    @(negedge clk);
    @(posedge clk);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
design/clic_pkg.sv
design/clic_table_if.sv
design/clic_csr_file.sv
design/clic_prio_arbiter.sv
design/clic_epc_stack.sv
design/clic_ctrl.sv
design/n_clic.sv
bench/clk_gen.sv
bench/n_clic_assertions.sv
bench/n_clic_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module n_clic_tb -f src.f -o sim_n_clic \
  || { echo "verilator build error"; exit 1; }
./obj_dir/sim_n_clic > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
